// File: filelist.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
tests/core_checker.sv
tests/tb_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the pass line
rm -f sim.log && \
verilator --binary --timing --timescale 1ns/1ps --top-module tb_core \
  -f filelist.f -o tb_core && \
./obj_dir/tb_core > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tests/tb_core.sv
`default_nettype none

module tb_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam word_t reset_vector = 32'h0000_0100;
  localparam int    num_tests    = 24;
  localparam int    trap_timeout = 20000;
  localparam int    mem_words    = 256;
  localparam word_t data_base    = 32'h0000_02c0;
  localparam word_t dump_base    = 32'h0000_0340;

  logic    clk = 1'b0;
  logic    reset = 1'b1;
  logic    mem_valid;
  logic    mem_instr;
  logic    trap;
  word_t   mem_addr;
  word_t   mem_wdata;
  strobe_t mem_wstrb;
  logic    mem_ready = 1'b0;
  word_t   mem_rdata = '0;
  logic    test_end = 1'b0;
  int      test_id = 0;
  int      error_count;
  int      tests_failed;

  integer  seed;
  word_t   prog [0:mem_words-1];
  word_t   mem [0:mem_words-1];
  word_t   ref_mem [0:mem_words-1];
  word_t   ref_regs [0:31];
  int      delays [0:1023];
  int      delay_idx = 0;
  int      delay_left = 0;
  int      code_len;

  // expected stores from the model
  word_t   exp_addr [0:255];
  strobe_t exp_strb [0:255];
  word_t   exp_data [0:255];
  int      exp_count = 0;

  always #10 clk = ~clk;

  rv_core #(.reset_vector(reset_vector)) rv_core_i (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  core_checker #(.reset_vector(reset_vector)) core_checker_i (
    .clk          (clk),
    .reset        (reset),
    .mem_valid    (mem_valid),
    .mem_instr    (mem_instr),
    .mem_ready    (mem_ready),
    .trap         (trap),
    .test_end     (test_end),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wstrb    (mem_wstrb),
    .test_id      (test_id),
    .exp_addr     (exp_addr),
    .exp_strb     (exp_strb),
    .exp_data     (exp_data),
    .exp_count    (exp_count),
    .error_count  (error_count),
    .tests_failed (tests_failed)
  );

  // memory with random ready delay and reload during reset
  always @(negedge clk) begin
    if (reset) begin
      mem        <= prog;
      mem_ready  <= 1'b0;
      delay_left <= delays[delay_idx % 1024];
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
    end else if (mem_valid) begin
      if (delay_left == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[9:2]];
        for (int b = 0; b < 4; b++) begin
          if (mem_wstrb[b]) begin
            mem[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
          end
        end
        delay_idx  <= delay_idx + 1;
        delay_left <= delays[(delay_idx + 1) % 1024];
      end else begin
        delay_left <= delay_left - 1;
      end
    end
  end

  function automatic word_t rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic int rand_below(int n);
    word_t w;
    w = rand_word();
    return int'(w % n);
  endfunction

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(1 + rand_below(31));
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd, opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd, opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic emit(word_t w);
    prog[reset_vector[9:2] + code_len] = w;
    code_len++;
  endtask

  // word store to the data area marks which path ran
  task automatic emit_marker();
    word_t w;
    w = rand_word();
    emit(enc_s(data_base[11:0] + {5'b0, w[6:2], 2'b00}, rand_reg(), 5'd0, 3'b010));
  endtask

  task automatic gen_alu_op();
    word_t      w;
    logic [2:0] f3;
    logic       alt;
    reg_addr_t  rd;
    reg_addr_t  r1;
    reg_addr_t  r2;
    int         kind;
    w    = rand_word();
    f3   = w[2:0];
    alt  = w[3];
    kind = rand_below(4);
    rd   = rand_reg();
    r1   = rand_reg();
    r2   = rand_reg();
    case (kind)
      0: emit(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? funct7_alt : funct7_base,
                    r2, r1, f3, rd, opc_op));
      1: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          emit(enc_i({(alt && f3 == 3'd5) ? funct7_alt : funct7_base, w[8:4]},
                     r1, f3, rd, opc_op_imm));
        end else begin
          emit(enc_i(w[31:20], r1, f3, rd, opc_op_imm));
        end
      end
      2: emit(enc_u(w[31:12], rd, opc_lui));
      default: emit(enc_u(w[31:12], rd, opc_auipc));
    endcase
  endtask

  task automatic gen_mem_op();
    word_t      w;
    word_t      base;
    reg_addr_t  rb;
    reg_addr_t  rv;
    logic [1:0] sz;
    logic [5:0] off;
    w    = rand_word();
    rb   = rand_reg();
    rv   = rand_reg();
    sz   = 2'(rand_below(3));
    base = data_base + word_t'({w[6:2], 2'b00});
    off  = w[13:8];
    if (sz == 2'd1) off[0] = 1'b0;
    if (sz == 2'd2) off[1:0] = 2'b00;
    emit(enc_i(base[11:0], 5'd0, 3'd0, rb, opc_op_imm));
    if (w[16]) begin
      emit(enc_s({6'b0, off}, rv, rb, {1'b0, sz}));
    end else begin
      emit(enc_i({6'b0, off}, rb, {(sz == 2'd2) ? 1'b0 : w[17], sz}, rv, opc_load));
    end
  endtask

  task automatic gen_flow_op();
    logic [2:0] bops [0:5];
    word_t      w;
    word_t      target;
    reg_addr_t  r1;
    reg_addr_t  rt;
    bops = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    w    = rand_word();
    r1   = rand_reg();
    case (rand_below(3))
      0: emit(enc_b(13'd8, w[0] ? r1 : rand_reg(), r1, bops[rand_below(6)]));
      1: emit(enc_j(21'd8, rand_reg()));
      default: begin
        // target skips the marker and may carry bit 0, which jalr drops
        rt     = rand_reg();
        target = (reset_vector + word_t'(code_len * 4 + 12)) | {31'b0, w[1]};
        emit(enc_i(target[11:0], 5'd0, 3'd0, rt, opc_op_imm));
        emit(enc_i(12'd0, rt, 3'd0, rand_reg(), opc_jalr));
      end
    endcase
    emit_marker();
  endtask

  task automatic gen_fault();
    word_t      w;
    logic [1:0] low;
    w   = rand_word();
    low = 2'(1 + rand_below(3));
    case (rand_below(5))
      0: emit(enc_i(12'h2c0 + {10'b0, low}, 5'd0, 3'b010, rand_reg(), opc_load));
      1: emit(enc_i(12'h2c0 + {10'b0, w[1], 1'b1}, 5'd0, 3'b001, rand_reg(), opc_load));
      2: emit(enc_s(12'h2c0 + {10'b0, low}, rand_reg(), 5'd0, 3'b010));
      3: emit(enc_s(12'h2c0 + {10'b0, w[1], 1'b1}, rand_reg(), 5'd0, 3'b001));
      default: emit(enc_j(21'd6, rand_reg()));
    endcase
    emit_marker();
  endtask

  task automatic build_program(int kind);
    word_t w;
    for (int i = 0; i < mem_words; i++) begin
      prog[i] = rand_word();
    end
    code_len = 0;
    for (int k = 1; k < 32; k++) begin
      w = rand_word();
      emit(enc_i(w[11:0], 5'd0, 3'd0, reg_addr_t'(k), opc_op_imm));
    end
    case (kind)
      0: repeat (20) gen_alu_op();
      1: repeat (12) gen_mem_op();
      2: repeat (10) gen_flow_op();
      default: begin
        repeat (4) gen_alu_op();
        gen_fault();
      end
    endcase
    for (int k = 1; k < 32; k++) begin
      emit(enc_s(dump_base[11:0] + 12'(4 * (k - 1)), reg_addr_t'(k), 5'd0, 3'b010));
    end
    // illegal word, ecall or ebreak
    w = rand_word();
    case (w[1:0])
      2'd0: emit(32'h0010_0073);
      2'd1: emit(32'h0000_0073);
      default: emit(32'h0000_0000);
    endcase
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic misaligned_ref(logic [1:0] sz, word_t addr);
    if (sz == 2'd2) return addr[1:0] != 2'b00;
    if (sz == 2'd1) return addr[0];
    return 1'b0;
  endfunction

  // instruction-set model that runs until the first trap
  task automatic run_model();
    word_t      pc;
    word_t      ins;
    word_t      next_pc;
    word_t      a;
    word_t      b;
    word_t      addr;
    word_t      val;
    word_t      lane;
    word_t      wd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    reg_addr_t  rd;
    logic [2:0] f3;
    logic       stop;
    logic       wen;
    strobe_t    st;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = prog[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    exp_count = 0;
    pc        = reset_vector;
    stop      = 1'b0;
    for (int steps = 0; steps < 2000 && !stop; steps++) begin
      ins     = ref_mem[pc[9:2]];
      rd      = ins[11:7];
      f3      = ins[14:12];
      a       = ref_regs[ins[19:15]];
      b       = ref_regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 32'd4;
      wen     = 1'b0;
      val     = '0;
      case (ins[6:0])
        opc_lui: begin
          wen = 1'b1;
          val = {ins[31:12], 12'b0};
        end
        opc_auipc: begin
          wen = 1'b1;
          val = pc + {ins[31:12], 12'b0};
        end
        opc_jal, opc_jalr: begin
          next_pc = (ins[6:0] == opc_jal) ? pc + imm_j : (a + imm_i) & ~32'd1;
          wen     = 1'b1;
          val     = pc + 32'd4;
          stop    = next_pc[1:0] != 2'b00;
        end
        opc_branch: begin
          if (branch_ref(f3, a, b)) next_pc = pc + imm_b;
          stop = next_pc[1:0] != 2'b00;
        end
        opc_op: begin
          wen = 1'b1;
          val = alu_ref(f3, ins[30], a, b);
        end
        opc_op_imm: begin
          wen = 1'b1;
          val = alu_ref(f3, f3 == 3'd5 && ins[30], a,
                        (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, ins[24:20]} : imm_i);
        end
        opc_load: begin
          addr = a + imm_i;
          stop = misaligned_ref(f3[1:0], addr);
          lane = ref_mem[addr[9:2]] >> {addr[1:0], 3'b000};
          wen  = 1'b1;
          case (f3[1:0])
            2'd0: val = f3[2] ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            2'd1: val = f3[2] ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
            default: val = lane;
          endcase
        end
        opc_store: begin
          addr = a + imm_s;
          stop = misaligned_ref(f3[1:0], addr);
          case (f3[1:0])
            2'd0: begin
              st = 4'b0001 << addr[1:0];
              wd = {4{b[7:0]}};
            end
            2'd1: begin
              st = 4'b0011 << addr[1:0];
              wd = {2{b[15:0]}};
            end
            default: begin
              st = 4'b1111;
              wd = b;
            end
          endcase
          if (!stop && exp_count < 256) begin
            exp_addr[exp_count] = {addr[31:2], 2'b00};
            exp_strb[exp_count] = st;
            exp_data[exp_count] = wd;
            exp_count++;
            for (int k = 0; k < 4; k++) begin
              if (st[k]) ref_mem[addr[9:2]][8*k +: 8] = wd[8*k +: 8];
            end
          end
        end
        default: stop = 1'b1;
      endcase
      if (!stop) begin
        if (wen && rd != 5'd0) ref_regs[rd] = val;
        pc = next_pc;
      end
    end
  endtask

  initial begin
    int    cycles;
    word_t w;
    logic  timed_out;
    seed      = 32'h0315192d;
    timed_out = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      w         = rand_word();
      delays[i] = int'(w[1:0]);
    end
    for (int t = 0; t < num_tests && !timed_out; t++) begin
      @(negedge clk);
      reset   = 1'b1;
      test_id = t;
      build_program(t % 4);
      run_model();
      repeat (4) @(negedge clk);
      reset  = 1'b0;
      cycles = 0;
      while (!trap && cycles < trap_timeout) begin
        @(negedge clk);
        cycles++;
      end
      if (!trap) begin
        $display("test %0d timed out waiting for the core to trap", t);
        timed_out = 1'b1;
      end else begin
        // quiet period where any request after the trap is flagged
        repeat (8) @(negedge clk);
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
      end
    end
    @(negedge clk);
    $display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, error_count);
    if (!timed_out && error_count == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/core_checker.sv
`default_nettype none

module core_checker #(
  parameter rv_pkg::word_t reset_vector = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_valid,
  input  logic              mem_instr,
  input  logic              mem_ready,
  input  logic              trap,
  input  logic              test_end,
  input  rv_pkg::word_t     mem_addr,
  input  rv_pkg::word_t     mem_wdata,
  input  rv_pkg::strobe_t   mem_wstrb,
  input  int                test_id,
  input  rv_pkg::word_t     exp_addr [0:255],
  input  rv_pkg::strobe_t   exp_strb [0:255],
  input  rv_pkg::word_t     exp_data [0:255],
  input  int                exp_count,
  output int                error_count,
  output int                tests_failed
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  int      write_idx = 0;
  int      test_errors = 0;
  int      errors_total = 0;
  int      failed_total = 0;
  int      reset_cycles = 0;
  logic    first_pending = 1'b1;
  logic    holding = 1'b0;
  word_t   held_addr;
  word_t   held_data;
  strobe_t held_strb;

  assign error_count  = errors_total;
  assign tests_failed = failed_total;

  task automatic check_value(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("error: %s expected %h actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report(string msg);
    $display("test %0d: %s", test_id, msg);
    test_errors++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (reset_cycles > 0 && (mem_valid || trap || mem_wstrb != '0)) begin
        report("bus request, strobe or trap active during reset");
      end
      reset_cycles++;
      write_idx     = 0;
      first_pending = 1'b1;
      holding       = 1'b0;
    end else begin
      reset_cycles = 0;
      if (first_pending && trap) report("trap rose before the first fetch");
      if (first_pending && mem_valid) begin
        first_pending = 1'b0;
        check_value("mem_instr", 32'd1, {31'b0, mem_instr});
        check_value("mem_addr", reset_vector, mem_addr);
      end
      // bus must hold while waiting for ready
      if (holding && mem_valid) begin
        check_value("mem_addr", held_addr, mem_addr);
        check_value("mem_wdata", held_data, mem_wdata);
        check_value("mem_wstrb", word_t'(held_strb), word_t'(mem_wstrb));
      end
      holding   = mem_valid && !mem_ready;
      held_addr = mem_addr;
      held_data = mem_wdata;
      held_strb = mem_wstrb;
      if (trap && mem_valid) report("bus request made after the trap");
      if (mem_valid && mem_ready && mem_wstrb != '0) begin
        check_value("mem_instr", 32'd0, {31'b0, mem_instr});
        if (write_idx >= exp_count) begin
          report("store seen beyond the expected sequence");
        end else begin
          check_value("mem_addr", exp_addr[write_idx], mem_addr);
          check_value("mem_wstrb", word_t'(exp_strb[write_idx]), word_t'(mem_wstrb));
          check_value("mem_wdata", exp_data[write_idx], mem_wdata);
        end
        write_idx++;
      end
    end
    if (test_end) begin
      if (write_idx != exp_count) begin
        $display("test %0d: %0d stores seen where %0d were expected",
                 test_id, write_idx, exp_count);
        test_errors++;
      end
      if (!trap) report("trap is not high at the end of the test");
      $display("test %0d: %0d stores, %s", test_id, write_idx,
               (test_errors == 0) ? "passed" : "failed");
      if (test_errors != 0) failed_total++;
      errors_total += test_errors;
      test_errors = 0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t reset_vector = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            reset,
  output logic            mem_valid,
  output logic            mem_instr,
  output rv_pkg::word_t   mem_addr,
  output rv_pkg::word_t   mem_wdata,
  output rv_pkg::strobe_t mem_wstrb,
  input  logic            mem_ready,
  input  rv_pkg::word_t   mem_rdata,
  output logic            trap
);
  import rv_pkg::*;

  core_state_t state;
  word_t       pc;
  word_t       next_pc;
  word_t       pc_plus_4;
  word_t       pc_target;
  word_t       instr;
  word_t       reg_wdata;

  reg_addr_t  rd, rs1, rs2;
  word_t      immediate;
  alu_op_t    alu_op;
  logic       use_immediate;
  branch_op_t branch_op;
  mem_size_t  mem_size;
  logic       load_unsigned;
  logic       is_lui, is_auipc, is_jal, is_jalr, is_branch;
  logic       is_load, is_store, is_alu, is_valid;

  word_t   rs1_data, rs2_data;
  word_t   alu_result;
  logic    branch_taken;
  word_t   lsu_addr;
  logic    lsu_misaligned;
  strobe_t lsu_wstrb;
  word_t   lsu_wdata;
  word_t   load_data;

  rv_decoder decoder_i (
    .instr         (instr),
    .rd            (rd),
    .rs1           (rs1),
    .rs2           (rs2),
    .immediate     (immediate),
    .alu_op        (alu_op),
    .use_immediate (use_immediate),
    .branch_op     (branch_op),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .is_lui        (is_lui),
    .is_auipc      (is_auipc),
    .is_jal        (is_jal),
    .is_jalr       (is_jalr),
    .is_branch     (is_branch),
    .is_load       (is_load),
    .is_store      (is_store),
    .is_alu        (is_alu),
    .is_valid      (is_valid)
  );

  rv_regfile regfile_i (
    .clk          (clk),
    .reset        (reset),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .write_enable (state == st_reg_write),
    .rd           (rd),
    .write_data   (reg_wdata)
  );

  rv_alu alu_i (
    .alu_op        (alu_op),
    .use_immediate (use_immediate),
    .branch_op     (branch_op),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .immediate     (immediate),
    .rs2           (rs2),
    .result        (alu_result),
    .branch_taken  (branch_taken)
  );

  // address stays valid in finish_load since instr and registers hold
  rv_lsu lsu_i (
    .is_store      (is_store),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .immediate     (immediate),
    .mem_rdata     (mem_rdata),
    .word_addr     (lsu_addr),
    .misaligned    (lsu_misaligned),
    .wstrb         (lsu_wstrb),
    .wdata         (lsu_wdata),
    .load_data     (load_data)
  );

  assign pc_plus_4 = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_fetch;
      next_pc   <= reset_vector;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      trap      <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= '0;
          mem_addr  <= next_pc;
          state     <= st_wait_instr;
        end
        st_wait_instr: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            pc        <= mem_addr;
            instr     <= mem_rdata;
            state     <= st_execute;
          end
        end
        st_execute: begin
          if (!is_valid) begin
            state <= st_trapped;
          end else if (is_lui || is_auipc || is_alu) begin
            reg_wdata <= is_lui ? immediate : (is_auipc ? pc + immediate : alu_result);
            next_pc   <= pc_plus_4;
            state     <= st_reg_write;
          end else if (is_jal || is_jalr) begin
            pc_target <= is_jalr ? (rs1_data + immediate) & ~32'd1 : pc + immediate;
            reg_wdata <= pc_plus_4;
            state     <= st_check_pc;
          end else if (is_branch) begin
            pc_target <= branch_taken ? pc + immediate : pc_plus_4;
            state     <= st_check_pc;
          end else if ((is_load || is_store) && !lsu_misaligned) begin
            mem_valid <= 1'b1;
            mem_instr <= 1'b0;
            mem_addr  <= lsu_addr;
            mem_wstrb <= lsu_wstrb;
            mem_wdata <= lsu_wdata;
            state     <= is_store ? st_finish_store : st_finish_load;
          end else begin
            state <= st_trapped;
          end
        end
        st_finish_load: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            reg_wdata <= load_data;
            next_pc   <= pc_plus_4;
            state     <= st_reg_write;
          end
        end
        st_finish_store: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_wstrb <= '0;
            next_pc   <= pc_plus_4;
            state     <= st_fetch;
          end
        end
        st_check_pc: begin
          // fetches must stay word aligned
          if (|pc_target[1:0]) begin
            state <= st_trapped;
          end else begin
            next_pc <= pc_target;
            state   <= is_branch ? st_fetch : st_reg_write;
          end
        end
        st_reg_write: begin
          state <= st_fetch;
        end
        default: begin
          trap <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/rv_lsu.sv
`default_nettype none

module rv_lsu (
  input  logic              is_store,
  input  rv_pkg::mem_size_t mem_size,
  input  logic              load_unsigned,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     immediate,
  input  rv_pkg::word_t     mem_rdata,
  output rv_pkg::word_t     word_addr,
  output logic              misaligned,
  output rv_pkg::strobe_t   wstrb,
  output rv_pkg::word_t     wdata,
  output rv_pkg::word_t     load_data
);
  import rv_pkg::*;

  word_t       addr;
  logic [1:0]  offset;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign addr      = rs1_data + immediate;
  assign offset    = addr[1:0];
  assign word_addr = {addr[xlen-1:2], 2'b00};

  always_comb begin
    case (mem_size)
      size_word: misaligned = |offset;
      size_half: misaligned = offset[0];
      default:   misaligned = 1'b0;
    endcase
  end

  // store data goes out on every lane, the strobe picks the bytes
  always_comb begin
    case (mem_size)
      size_byte: begin
        wstrb = 4'b0001 << offset;
        wdata = {4{rs2_data[7:0]}};
      end
      size_half: begin
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
        wdata = {2{rs2_data[15:0]}};
      end
      default: begin
        wstrb = 4'b1111;
        wdata = rs2_data;
      end
    endcase
    if (!is_store) begin
      wstrb = '0;
    end
  end

  always_comb begin
    case (offset)
      2'd0:    load_byte = mem_rdata[7:0];
      2'd1:    load_byte = mem_rdata[15:8];
      2'd2:    load_byte = mem_rdata[23:16];
      default: load_byte = mem_rdata[31:24];
    endcase
  end

  assign load_half = offset[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (mem_size)
      size_byte: load_data = {{24{load_byte[7] & ~load_unsigned}}, load_byte};
      size_half: load_data = {{16{load_half[15] & ~load_unsigned}}, load_half};
      default:   load_data = mem_rdata;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_t    alu_op,
  input  logic               use_immediate,
  input  rv_pkg::branch_op_t branch_op,
  input  rv_pkg::word_t      rs1_data,
  input  rv_pkg::word_t      rs2_data,
  input  rv_pkg::word_t      immediate,
  input  rv_pkg::reg_addr_t  rs2,
  output rv_pkg::word_t      result,
  output logic               branch_taken
);
  import rv_pkg::*;

  word_t      operand_b;
  logic [4:0] shamt;
  logic       equal;
  logic       less_signed;
  logic       less_unsigned;

  assign operand_b = use_immediate ? immediate : rs2_data;
  // immediate shifts carry the amount in the rs2 field
  assign shamt     = use_immediate ? rs2 : rs2_data[4:0];

  always_comb begin
    case (alu_op)
      alu_add:  result = rs1_data + operand_b;
      alu_sub:  result = rs1_data - operand_b;
      alu_sll:  result = rs1_data << shamt;
      alu_slt:  result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      alu_sltu: result = {31'b0, rs1_data < operand_b};
      alu_xor:  result = rs1_data ^ operand_b;
      alu_srl:  result = rs1_data >> shamt;
      alu_sra:  result = $signed(rs1_data) >>> shamt;
      alu_or:   result = rs1_data | operand_b;
      default:  result = rs1_data & operand_b;
    endcase
  end

  // branches always compare two registers
  assign equal         = rs1_data == rs2_data;
  assign less_signed   = $signed(rs1_data) < $signed(rs2_data);
  assign less_unsigned = rs1_data < rs2_data;

  always_comb begin
    case (branch_op)
      br_eq:   branch_taken = equal;
      br_ne:   branch_taken = !equal;
      br_lt:   branch_taken = less_signed;
      br_ge:   branch_taken = !less_signed;
      br_ltu:  branch_taken = less_unsigned;
      default: branch_taken = !less_unsigned;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              write_enable,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     write_data
);
  import rv_pkg::*;

  // entry 0 is never written
  word_t regs [0:31];

  always_ff @(posedge clk) begin
    if (write_enable && !reset && rd != '0) begin
      regs[rd] <= write_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`default_nettype none

module rv_decoder (
  input  rv_pkg::word_t      instr,
  output rv_pkg::reg_addr_t  rd,
  output rv_pkg::reg_addr_t  rs1,
  output rv_pkg::reg_addr_t  rs2,
  output rv_pkg::word_t      immediate,
  output rv_pkg::alu_op_t    alu_op,
  output logic               use_immediate,
  output rv_pkg::branch_op_t branch_op,
  output rv_pkg::mem_size_t  mem_size,
  output logic               load_unsigned,
  output logic               is_lui,
  output logic               is_auipc,
  output logic               is_jal,
  output logic               is_jalr,
  output logic               is_branch,
  output logic               is_load,
  output logic               is_store,
  output logic               is_alu,
  output logic               is_valid
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt_select;
  logic       shift_op;
  logic       funct7_ok;

  assign opcode = opcode_t'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign is_lui    = opcode == opc_lui;
  assign is_auipc  = opcode == opc_auipc;
  assign is_jal    = opcode == opc_jal;
  assign is_jalr   = opcode == opc_jalr;
  assign is_branch = opcode == opc_branch;
  assign is_load   = opcode == opc_load;
  assign is_store  = opcode == opc_store;
  assign is_alu    = opcode == opc_op || opcode == opc_op_imm;

  assign use_immediate = opcode == opc_op_imm;
  assign branch_op     = branch_op_t'(funct3);
  assign mem_size      = funct3[1] ? size_word : (funct3[0] ? size_half : size_byte);
  assign load_unsigned = funct3[2];

  // only add/sub and the right shifts have an alternate funct7
  assign alt_select = funct7 == funct7_alt;
  assign shift_op   = funct3 == f3_sll || funct3 == f3_srl_sra;
  assign funct7_ok  = funct7 == funct7_base ||
                      (alt_select && (funct3 == f3_add_sub || funct3 == f3_srl_sra));

  always_comb begin
    case (opcode)
      opc_lui, opc_auipc: immediate = {instr[31:12], 12'b0};
      opc_jal:    immediate = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      opc_branch: immediate = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      opc_store:  immediate = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      default:    immediate = {{21{instr[31]}}, instr[30:20]};
    endcase
  end

  always_comb begin
    case (funct3)
      f3_add_sub: alu_op = (alt_select && opcode == opc_op) ? alu_sub : alu_add;
      f3_sll:     alu_op = alu_sll;
      f3_slt:     alu_op = alu_slt;
      f3_sltu:    alu_op = alu_sltu;
      f3_xor:     alu_op = alu_xor;
      f3_srl_sra: alu_op = alt_select ? alu_sra : alu_srl;
      f3_or:      alu_op = alu_or;
      default:    alu_op = alu_and;
    endcase
  end

  // system and csr encodings fall to the default
  always_comb begin
    case (opcode)
      opc_lui, opc_auipc, opc_jal: is_valid = 1'b1;
      opc_jalr:   is_valid = funct3 == f3_jalr;
      opc_branch: is_valid = funct3[2:1] != 2'b01;
      opc_load:   is_valid = funct3[1:0] != 2'b11 && !(funct3[2] && funct3[1]);
      opc_store:  is_valid = !funct3[2] && funct3[1:0] != 2'b11;
      opc_op:     is_valid = funct7_ok;
      opc_op_imm: is_valid = !shift_op || funct7_ok;
      default:    is_valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      strobe_t;

  // major opcodes, low seven bits of the instruction
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_t;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_jalr    = 3'b000;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  // values equal the branch funct3 field
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_op_t;

  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_t;

  typedef enum logic [2:0] {
    st_fetch, st_wait_instr, st_execute, st_finish_load,
    st_finish_store, st_check_pc, st_reg_write, st_trapped
  } core_state_t;

endpackage

`default_nettype wire
